//--- hw/ooo_cfg_pkg.sv
// --------------------------------------
// sizing of the issue/execute slice
// import wherever widths, station count or
// unit latencies are needed
// --------------------------------------

package ooo_cfg_pkg;

    // data path
    localparam int XLEN = 32;

    // zero rob tag means operand present or bus idle
    localparam int ROB_TAG_W = 4;
    localparam logic [ROB_TAG_W-1:0] TAG_NONE = '0;

    // reservation stations
    localparam int NUM_RS = 4;
    // NUM_RS and up on the selector picks no station
    localparam int RS_SEL_W = 3;

    // unit latencies in cycles spent in SCHED_EXEC
    localparam int LAT_ALU = 1;
    localparam int LAT_MUL = 3;

    // latency timer width, holds LAT_MUL - 1
    localparam int LAT_W = 2;

endpackage

//--- hw/ooo_types_pkg.sv
// --------------------------------------
// operation encodings and the structs passed
// between rename, stations, scheduler and CDB
// --------------------------------------

package ooo_types_pkg;

    import ooo_cfg_pkg::*;

    // integer unit operations
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLT = 3'd5,
        OP_SLL = 3'd6,
        OP_MUL = 3'd7
    } alu_op_e;

    // anything but BR_NONE overrides alu_op with a signed compare
    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_EQ   = 2'd1,
        BR_NE   = 2'd2,
        BR_LT   = 2'd3
    } branch_e;

    // one station entry and the issue payload from rename
    typedef struct packed {
        logic [ROB_TAG_W-1:0] q_j;
        logic [ROB_TAG_W-1:0] q_k;
        logic [XLEN-1:0]      v_j;
        logic [XLEN-1:0]      v_k;
        logic [ROB_TAG_W-1:0] rob_entry;
        alu_op_e              alu_op;
        branch_e              branch_type;
        logic                 busy;
    } rs_data_t;

    // common data bus broadcast
    typedef struct packed {
        logic [ROB_TAG_W-1:0] dest_rob;
        logic [XLEN-1:0]      result;
    } cdb_packet_t;

    // station view seen by the scheduler
    typedef struct packed {
        logic                 valid_operands;
        alu_op_e              alu_op;
        branch_e              branch_type;
        logic [ROB_TAG_W-1:0] rob_entry;
        logic [XLEN-1:0]      src1;
        logic [XLEN-1:0]      src2;
    } rs_out_t;

    typedef enum logic [1:0] {
        SCHED_IDLE  = 2'd0,
        SCHED_EXEC  = 2'd1,
        SCHED_BCAST = 2'd2
    } sched_state_e;

endpackage

//--- hw/exec_timer.sv
// --------------------------------------
// latency counter for the integer unit
// load with latency minus one, done at zero
// --------------------------------------

`timescale 1ns/1ps

module exec_timer (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          mispredicted,
    input  logic                          load,
    input  logic [ooo_cfg_pkg::LAT_W-1:0] len,
    output logic                          done
);
    import ooo_cfg_pkg::*;

    logic [LAT_W-1:0] count;
    logic             running;

    always_ff @(posedge clk) begin
        if (reset || mispredicted) begin
            // a flush aborts the op being timed
            running <= 1'b0;
            count   <= '0;
        end else if (load) begin
            running <= 1'b1;
            count   <= len;
        end else if (running) begin
            if (count == '0) begin
                running <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    assign done = running && (count == '0);

endmodule

//--- hw/int_exec_unit.sv
// --------------------------------------
// shared integer unit: ALU, multiply and
// branch compare on operands latched at start
// --------------------------------------

`timescale 1ns/1ps

module int_exec_unit (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    input  ooo_types_pkg::rs_out_t       dispatch,
    output logic [ooo_cfg_pkg::XLEN-1:0] result
);
    import ooo_cfg_pkg::*;
    import ooo_types_pkg::*;

    alu_op_e         op_q;
    branch_e         br_q;
    logic [XLEN-1:0] a_q;
    logic [XLEN-1:0] b_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            op_q <= OP_ADD;
            br_q <= BR_NONE;
        end else if (start) begin
            op_q <= dispatch.alu_op;
            br_q <= dispatch.branch_type;
        end
    end

    // operands held until the next dispatch
    always_ff @(posedge clk) begin
        if (start) begin
            a_q <= dispatch.src1;
            b_q <= dispatch.src2;
        end
    end

    always_comb begin
        case (br_q)
            BR_EQ:   result = {{(XLEN-1){1'b0}}, a_q == b_q};
            BR_NE:   result = {{(XLEN-1){1'b0}}, a_q != b_q};
            BR_LT:   result = {{(XLEN-1){1'b0}}, $signed(a_q) < $signed(b_q)};
            default: begin
                case (op_q)
                    OP_ADD:  result = a_q + b_q;
                    OP_SUB:  result = a_q - b_q;
                    OP_AND:  result = a_q & b_q;
                    OP_OR:   result = a_q | b_q;
                    OP_XOR:  result = a_q ^ b_q;
                    OP_SLT:  result = {{(XLEN-1){1'b0}}, $signed(a_q) < $signed(b_q)};
                    OP_SLL:  result = a_q << b_q[4:0];
                    // low word of the product only
                    OP_MUL:  result = a_q * b_q;
                    default: result = '0;
                endcase
            end
        endcase
    end

endmodule

//--- hw/rs_bank.sv
// --------------------------------------
// bank of reservation stations
// written by issue, woken by the CDB,
// emptied by consume or mispredict flush
// --------------------------------------

`timescale 1ns/1ps

module rs_bank (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   stall,
    input  logic                                   mispredicted,
    input  logic [ooo_cfg_pkg::RS_SEL_W-1:0]       issue_sel,
    input  ooo_types_pkg::rs_data_t                issue_data,
    input  ooo_types_pkg::cdb_packet_t             cdb,
    input  logic [ooo_cfg_pkg::NUM_RS-1:0]         consumed,
    output logic [ooo_cfg_pkg::NUM_RS-1:0]         busy_bus,
    output ooo_types_pkg::rs_out_t [ooo_cfg_pkg::NUM_RS-1:0] rs_out
);
    import ooo_cfg_pkg::*;
    import ooo_types_pkg::*;

    logic     cdb_active;
    rs_data_t issue_bypassed;

    assign cdb_active = (cdb.dest_rob != TAG_NONE);

    // same-cycle bypass of a result broadcast while the entry is being written
    always_comb begin
        issue_bypassed = issue_data;
        if (cdb_active && issue_data.q_j == cdb.dest_rob) begin
            issue_bypassed.q_j = TAG_NONE;
            issue_bypassed.v_j = cdb.result;
        end
        if (cdb_active && issue_data.q_k == cdb.dest_rob) begin
            issue_bypassed.q_k = TAG_NONE;
            issue_bypassed.v_k = cdb.result;
        end
    end

    for (genvar i = 0; i < NUM_RS; i++) begin : g_rs
        rs_data_t entry;
        logic     valid_q;
        logic     wr_en;
        logic     clr;

        assign wr_en = (issue_sel == RS_SEL_W'(i)) && !stall;
        assign clr   = reset || mispredicted || consumed[i];

        // clear beats write and write beats wakeup
        always_ff @(posedge clk) begin
            if (clr) begin
                entry.busy <= 1'b0;
                entry.q_j  <= TAG_NONE;
                entry.q_k  <= TAG_NONE;
            end else if (wr_en) begin
                entry <= issue_bypassed;
            end else begin
                // operand wakeup from the bus
                if (cdb_active && entry.q_j == cdb.dest_rob) begin
                    entry.q_j <= TAG_NONE;
                    entry.v_j <= cdb.result;
                end
                if (cdb_active && entry.q_k == cdb.dest_rob) begin
                    entry.q_k <= TAG_NONE;
                    entry.v_k <= cdb.result;
                end
            end
        end

        // ready lags the tags by one cycle, and never shows for an empty entry
        always_ff @(posedge clk) begin
            if (clr || wr_en) begin
                valid_q <= 1'b0;
            end else begin
                valid_q <= entry.busy && entry.q_j == TAG_NONE && entry.q_k == TAG_NONE;
            end
        end

        assign busy_bus[i]              = entry.busy;
        assign rs_out[i].valid_operands = valid_q;
        assign rs_out[i].alu_op         = entry.alu_op;
        assign rs_out[i].branch_type    = entry.branch_type;
        assign rs_out[i].rob_entry      = entry.rob_entry;
        assign rs_out[i].src1           = entry.v_j;
        assign rs_out[i].src2           = entry.v_k;

        // rename must pick a free station
        a_no_overwrite: assert property (@(posedge clk) disable iff (reset)
            (wr_en && !mispredicted) |-> !entry.busy)
            else $error("issue to busy station %0d", i);
    end

    // scheduler takes at most one station, and only one holding an instruction
    a_consume_legal: assert property (@(posedge clk) disable iff (reset)
        $onehot0(consumed) && ((consumed & ~busy_bus) == '0))
        else $error("illegal consume pattern %b, busy %b", consumed, busy_bus);

endmodule

//--- hw/issue_scheduler.sv
// --------------------------------------
// dispatch FSM for the shared integer unit
// picks a ready station, times the op and
// drives the CDB for one cycle
// --------------------------------------

`timescale 1ns/1ps

module issue_scheduler (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    mispredicted,
    input  ooo_types_pkg::rs_out_t [ooo_cfg_pkg::NUM_RS-1:0] rs_out,
    input  logic [ooo_cfg_pkg::XLEN-1:0]            result,
    input  logic                                    timer_done,
    output logic [ooo_cfg_pkg::NUM_RS-1:0]          consumed,
    output logic                                    exec_start,
    output ooo_types_pkg::rs_out_t                  dispatch,
    output logic                                    timer_load,
    output logic [ooo_cfg_pkg::LAT_W-1:0]           timer_len,
    output ooo_types_pkg::cdb_packet_t              cdb
);
    import ooo_cfg_pkg::*;
    import ooo_types_pkg::*;

    sched_state_e         state;
    logic [NUM_RS-1:0]    pick;
    logic [ROB_TAG_W-1:0] inflight_tag;

    // fixed priority with station 0 first
    always_comb begin
        pick     = '0;
        dispatch = rs_out[0];
        for (int i = NUM_RS - 1; i >= 0; i--) begin
            if (rs_out[i].valid_operands) begin
                pick     = '0;
                pick[i]  = 1'b1;
                dispatch = rs_out[i];
            end
        end
    end

    assign exec_start = (state == SCHED_IDLE) && (pick != '0) && !mispredicted;
    assign consumed   = exec_start ? pick : '0;
    assign timer_load = exec_start;

    // branches use the ALU path whatever alu_op says
    assign timer_len = (dispatch.branch_type == BR_NONE && dispatch.alu_op == OP_MUL) ?
                       LAT_W'(LAT_MUL - 1) : LAT_W'(LAT_ALU - 1);

    always_ff @(posedge clk) begin
        if (reset || mispredicted) begin
            state        <= SCHED_IDLE;
            cdb.dest_rob <= TAG_NONE;
        end else begin
            case (state)
                SCHED_IDLE: begin
                    if (exec_start) begin
                        inflight_tag <= dispatch.rob_entry;
                        state        <= SCHED_EXEC;
                    end
                end
                SCHED_EXEC: begin
                    if (timer_done) begin
                        cdb.dest_rob <= inflight_tag;
                        cdb.result   <= result;
                        state        <= SCHED_BCAST;
                    end
                end
                SCHED_BCAST: begin
                    // bus goes idle after one cycle
                    cdb.dest_rob <= TAG_NONE;
                    state        <= SCHED_IDLE;
                end
                default: begin
                    cdb.dest_rob <= TAG_NONE;
                    state        <= SCHED_IDLE;
                end
            endcase
        end
    end

    // the timer may only finish while the single op in flight executes
    a_single_inflight: assert property (@(posedge clk) disable iff (reset)
        timer_done |-> (state == SCHED_EXEC))
        else $error("timer done outside execution, rob %0d", inflight_tag);

endmodule

//--- hw/issue_exec_top.sv
// --------------------------------------
// issue-to-execute slice top level
// stations, scheduler, timer and integer unit
// --------------------------------------

`timescale 1ns/1ps

module issue_exec_top (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             stall,
    input  logic                             mispredicted,
    input  logic [ooo_cfg_pkg::RS_SEL_W-1:0] issue_sel,
    input  ooo_types_pkg::rs_data_t          issue_data,
    output logic [ooo_cfg_pkg::NUM_RS-1:0]   busy_bus,
    output ooo_types_pkg::cdb_packet_t       cdb
);
    import ooo_cfg_pkg::*;
    import ooo_types_pkg::*;

    rs_out_t [NUM_RS-1:0] rs_out;
    logic [NUM_RS-1:0]    consumed;
    logic                 exec_start;
    rs_out_t              dispatch;
    logic                 timer_load;
    logic [LAT_W-1:0]     timer_len;
    logic                 timer_done;
    logic [XLEN-1:0]      result;

    rs_bank i_rs_bank (
        .clk, .reset, .stall, .mispredicted,
        .issue_sel, .issue_data, .cdb, .consumed,
        .busy_bus, .rs_out
    );

    issue_scheduler i_issue_scheduler (
        .clk, .reset, .mispredicted,
        .rs_out, .result, .timer_done,
        .consumed, .exec_start, .dispatch,
        .timer_load, .timer_len, .cdb
    );

    exec_timer i_exec_timer (
        .clk, .reset, .mispredicted,
        .load (timer_load),
        .len  (timer_len),
        .done (timer_done)
    );

    int_exec_unit i_int_exec_unit (
        .clk, .reset,
        .start (exec_start),
        .dispatch,
        .result
    );

endmodule

//--- verification/tb_issue_exec.sv
// ----------------------------------------
// testbench for the issue-to-execute slice
// runs the command list in the stim file and
// scores every CDB broadcast by ROB tag
// ----------------------------------------

`timescale 1ns/1ps

module tb_issue_exec;
    import ooo_cfg_pkg::*;
    import ooo_types_pkg::*;

    localparam int MAX_CMDS = 128;
    localparam int NUM_TAGS = 2 ** ROB_TAG_W;
    localparam logic [RS_SEL_W-1:0] SEL_NONE = RS_SEL_W'(NUM_RS);

    logic                clk;
    logic                reset;
    logic                stall;
    logic                mispredicted;
    logic [RS_SEL_W-1:0] issue_sel;
    rs_data_t            issue_data;
    logic [NUM_RS-1:0]   busy_bus;
    cdb_packet_t         cdb;

    // command list from the stim file
    byte         cmd_op   [MAX_CMDS];
    logic [31:0] cmd_arg  [MAX_CMDS][8];
    string       cmd_name [MAX_CMDS];
    int          num_cmds;

    // expected broadcasts indexed by rob tag
    logic [XLEN-1:0] exp_result [NUM_TAGS];
    logic            exp_armed  [NUM_TAGS];
    logic            exp_seen   [NUM_TAGS];
    string           exp_test   [NUM_TAGS];

    // station occupancy as seen from outside
    logic [NUM_RS-1:0]    model_busy;
    logic [ROB_TAG_W-1:0] model_tag [NUM_RS];

    string test_name;
    int    stall_left;
    int    mismatch_count;
    int    other_count;
    int    cycle_count = 0;
    int    cycle_limit = 0;

    issue_exec_top i_issue_exec_top (
        .clk, .reset, .stall, .mispredicted,
        .issue_sel, .issue_data, .busy_bus, .cdb
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // limit is armed once the stim file is read
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check_busy(input logic [NUM_RS-1:0] expected, input logic [NUM_RS-1:0] actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH %s busy_bus: expected %b, actual %b", test_name, expected, actual);
        end
    endtask

    task automatic check_cdb(input cdb_packet_t got);
        int tag;
        tag = int'(got.dest_rob);
        if (!exp_armed[tag]) begin
            other_count++;
            $display("%s: rob tag %0d was broadcast but nothing was expected", test_name, tag);
        end else if (exp_seen[tag]) begin
            other_count++;
            $display("%s: rob tag %0d was broadcast a second time", test_name, tag);
        end else begin
            exp_seen[tag] = 1'b1;
            if (got.result !== exp_result[tag]) begin
                mismatch_count++;
                $display("MISMATCH %s cdb rob %0d: expected %h, actual %h",
                         exp_test[tag], tag, exp_result[tag], got.result);
            end
        end
    endtask

    // sampled mid-cycle since each broadcast lasts one cycle
    task automatic watch_cdb();
        forever begin
            @(negedge clk);
            if (cdb.dest_rob != TAG_NONE) begin
                check_cdb(cdb);
                for (int i = 0; i < NUM_RS; i++) begin
                    if (model_busy[i] && model_tag[i] == cdb.dest_rob) begin
                        model_busy[i] = 1'b0;
                    end
                end
            end
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
        if (stall_left > 0) begin
            stall_left--;
        end
        stall = (stall_left != 0);
    endtask

    task automatic load_stim();
        int          fd;
        int          code;
        int          want;
        int          wait_sum;
        int          issue_count;
        string       line;
        string       word;
        logic [31:0] f0, f1, f2, f3, f4, f5, f6, f7;
        num_cmds = 0;
        fd = $fopen("verification/issue_exec_stim.txt", "r");
        if (fd == 0) begin
            other_count++;
            $display("cannot open the stim file");
        end else begin
            wait_sum = 0;
            issue_count = 0;
            while ($fgets(line, fd) != 0) begin
                want = -1;
                code = 0;
                case (line[0])
                    "I": begin
                        want = 8;
                        code = $sscanf(line, "I %h %h %h %h %h %h %h %h",
                                       f0, f1, f2, f3, f4, f5, f6, f7);
                        issue_count++;
                    end
                    "W": begin
                        want = 2;
                        code = $sscanf(line, "W %d %d", f0, f1);
                        wait_sum += int'(f0);
                    end
                    "S": begin
                        want = 1;
                        code = $sscanf(line, "S %d", f0);
                    end
                    "E": begin
                        want = 2;
                        code = $sscanf(line, "E %h %h", f0, f1);
                    end
                    "T": begin
                        want = 1;
                        code = $sscanf(line, "T %s", word);
                    end
                    "F": want = 0;
                    default: ;
                endcase
                if (want >= 0) begin
                    if (code != want || num_cmds == MAX_CMDS) begin
                        other_count++;
                        $display("stim line not understood: %s", line);
                    end else begin
                        cmd_op[num_cmds]   = line[0];
                        cmd_arg[num_cmds]  = '{f0, f1, f2, f3, f4, f5, f6, f7};
                        cmd_name[num_cmds] = word;
                        num_cmds++;
                    end
                end
            end
            $fclose(fd);
            cycle_limit = wait_sum + 6 * issue_count + 50;
        end
    endtask

    task automatic run_command(input int n);
        rs_data_t d;
        int       tag;
        case (cmd_op[n])
            "T": test_name = cmd_name[n];
            "S": begin
                stall_left = int'(cmd_arg[n][0]);
                stall = (stall_left != 0);
            end
            "W": begin
                repeat (int'(cmd_arg[n][0])) next_cycle();
                // only settled waits ask for a busy compare
                if (cmd_arg[n][1] != 0) begin
                    check_busy(model_busy, busy_bus);
                end
            end
            "F": begin
                mispredicted = 1'b1;
                next_cycle();
                mispredicted = 1'b0;
                model_busy = '0;
                check_busy(model_busy, busy_bus);
            end
            "E": begin
                tag = int'(cmd_arg[n][0][ROB_TAG_W-1:0]);
                if (exp_armed[tag] && !exp_seen[tag]) begin
                    other_count++;
                    $display("%s: rob tag %0d re-armed before it was broadcast", test_name, tag);
                end
                exp_result[tag] = cmd_arg[n][1];
                exp_armed[tag]  = 1'b1;
                exp_seen[tag]   = 1'b0;
                exp_test[tag]   = test_name;
            end
            "I": begin
                d.q_j         = cmd_arg[n][1][ROB_TAG_W-1:0];
                d.q_k         = cmd_arg[n][2][ROB_TAG_W-1:0];
                d.v_j         = cmd_arg[n][3];
                d.v_k         = cmd_arg[n][4];
                d.rob_entry   = cmd_arg[n][5][ROB_TAG_W-1:0];
                d.alu_op      = alu_op_e'(cmd_arg[n][6][2:0]);
                d.branch_type = branch_e'(cmd_arg[n][7][1:0]);
                d.busy        = 1'b1;
                issue_sel  = cmd_arg[n][0][RS_SEL_W-1:0];
                issue_data = d;
                // a stalled issue must leave the stations alone
                if (!stall && cmd_arg[n][0] < NUM_RS) begin
                    model_busy[int'(cmd_arg[n][0])] = 1'b1;
                    model_tag[int'(cmd_arg[n][0])]  = d.rob_entry;
                end
                next_cycle();
                issue_sel  = SEL_NONE;
                issue_data = '0;
            end
            default: ;
        endcase
    endtask

    initial begin
        reset = 1'b1;
        stall = 1'b0;
        mispredicted = 1'b0;
        issue_sel = SEL_NONE;
        issue_data = '0;
        mismatch_count = 0;
        other_count = 0;
        stall_left = 0;
        model_busy = '0;
        test_name = "reset";
        for (int t = 0; t < NUM_TAGS; t++) begin
            exp_armed[t] = 1'b0;
            exp_seen[t]  = 1'b0;
        end
        load_stim();
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        check_busy('0, busy_bus);
        if (cdb.dest_rob != TAG_NONE) begin
            other_count++;
            $display("cdb not idle after reset");
        end
        fork
            watch_cdb();
        join_none
        for (int n = 0; n < num_cmds; n++) begin
            run_command(n);
        end
        for (int t = 1; t < NUM_TAGS; t++) begin
            if (exp_armed[t] && !exp_seen[t]) begin
                other_count++;
                $display("%s: rob tag %0d was never broadcast", exp_test[t], t);
            end
        end
        $display("%0d mismatches, %0d other errors", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- verification/issue_exec_stim.txt
# I sel q_j q_k v_j v_k rob op br (hex) | E rob result (hex) | T name
# W cycles busy_check (dec) | S stall_cycles (dec) | F flush
T alu_ops
E 1 23456789
E 2 fffffffe
E 3 00f000f0
E 4 f000000f
I 0 0 0 12345678 11111111 1 0 0
I 1 0 0 00000005 00000007 2 1 0
I 2 0 0 f0f0f0f0 0ff00ff0 3 2 0
I 3 0 0 f0000000 0000000f 4 3 0
W 20 1
E 5 55555555
E 6 00000001
E 7 00000030
I 0 0 0 aaaa5555 ffff0000 5 4 0
I 1 0 0 ffffffff 00000001 6 5 0
I 2 0 0 00000003 00000024 7 6 0
W 20 1
T dep_chain
E 9 00000030
E a 00000035
E b 00000fd0
I 0 0 0 00000010 00000020 9 0 0
I 1 9 0 00000000 00000005 a 0 0
W 2 0
I 2 0 9 00001000 00000000 b 1 0
W 20 1
T mul_branch
E 1 23450000
E 2 00000001
E 3 00000000
E 4 00000001
I 0 0 0 00012345 00010000 1 7 0
I 1 0 0 00000007 00000007 2 7 1
I 2 0 0 00000007 00000007 3 0 2
I 3 0 0 fffffff0 00000002 4 0 3
W 25 1
T flush
I 0 0 0 00000003 00000004 d 7 0
I 1 d 0 00000000 00000001 e 0 0
W 1 0
F
W 10 1
T stall
S 2
I 0 0 0 00000001 00000002 f 0 0
W 6 1
E f 00000003
I 0 0 0 00000001 00000002 f 0 0
W 10 1

//--- sim.f
hw/ooo_cfg_pkg.sv
hw/ooo_types_pkg.sv
hw/exec_timer.sv
hw/int_exec_unit.sv
hw/rs_bank.sv
hw/issue_scheduler.sv
hw/issue_exec_top.sv
verification/tb_issue_exec.sv

//--- Makefile
TOP := tb_issue_exec
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f sim.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
